//--- src.f
+incdir+include
design/icache_pkg.sv
design/icache_refill_if.sv
design/bram_sdp.sv
design/lru_way_select.sv
design/refill_buffer.sv
design/icache_ctrl.sv
design/icache.sv
tb/tb_clock_gen.sv
tb/icache_props.sv
tb/icache_checker.sv
tb/tb_icache.sv

//--- tb/tb_icache.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module tb_icache;

    localparam logic [31:0] seed  = 32'h1947d176;
    localparam int directed_reqs  = 6;
    localparam int random_reqs    = 400;
    localparam int max_mem_delay  = 5;
    localparam int timeout_cycles = 20 * (directed_reqs + random_reqs) * max_mem_delay;

    logic                      clk;
    logic                      rst_n;
    logic [`ICACHE_WORD_W-1:0] pc;
    logic                      fetch_valid;
    logic                      stall;
    logic                      flush;
    logic                      fetch_ready;
    logic [`ICACHE_WORD_W-1:0] inst;
    logic                      inst_valid;
    logic [`ICACHE_WORD_W-1:0] load_addr;
    logic                      mem_valid;
    logic                      mem_ready = 1'b0;
    logic [`ICACHE_LINE_W-1:0] mem_line = '0;

    logic        drained;
    int unsigned requests;
    int unsigned checks;
    int unsigned errors;
    int unsigned issued;
    int unsigned cycles = 0;
    logic        taken;
    logic [31:0] rng;
    logic [31:0] mem_rng = 32'h0;
    logic        mem_busy = 1'b0;
    int          delay_left = 0;

    tb_clock_gen #(.period_ns(8)) u_clk (.clk(clk));

    icache u_icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .fetch_ready (fetch_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .load_addr   (load_addr),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_line    (mem_line)
    );

    icache_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .fetch_ready (fetch_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .load_addr   (load_addr),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .drained     (drained),
        .requests    (requests),
        .checks      (checks),
        .errors      (errors)
    );

    bind icache icache_props u_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .fetch_ready (fetch_ready),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .load_addr   (load_addr),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] line_pc(input logic [21:0] tag, input logic [5:0] set,
                                            input logic [1:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    // Four tags over four sets, so two ways keep conflicting
    function automatic logic [31:0] pick_pc(input logic [31:0] r);
        return line_pc({20'h00040, r[1:0]}, {4'b0000, r[3:2]}, r[5:4]);
    endfunction

    // Present one pc and hold it until the cache takes it
    task automatic fetch_one(input logic [31:0] addr);
        pc          <= addr;
        fetch_valid <= 1'b1;
        do
            @(posedge clk);
        while (!(fetch_valid && fetch_ready && !stall));
        fetch_valid <= 1'b0;
    endtask

    //////////////////////////////
    // Memory responder

    // Line comes back 0 to 5 cycles after the request shows up
    always @(posedge clk)
    begin
        if (!rst_n || !mem_valid || mem_ready)
        begin
            mem_ready <= 1'b0;
            mem_busy = 1'b0;
        end
        else
        begin
            if (!mem_busy)
            begin
                mem_rng    = xorshift32(mem_rng == 0 ? xorshift32(seed) : mem_rng);
                delay_left = int'(mem_rng % (max_mem_delay + 1));
                mem_busy   = 1'b1;
            end
            if (delay_left == 0)
            begin
                mem_ready <= 1'b1;
                mem_line  <= u_checker.line_image(load_addr);
            end
            else
            begin
                delay_left = delay_left - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > timeout_cycles)
        begin
            $display("Timeout, requests still open after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus

    initial
    begin
        rst_n       = 1'b0;
        pc          = '0;
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        rng         = seed;
        issued      = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Set 9 sees A B A C, so A stays and B was evicted
        fetch_one(line_pc(22'h000101, 6'd9, 2'd0));
        fetch_one(line_pc(22'h000202, 6'd9, 2'd1));
        fetch_one(line_pc(22'h000101, 6'd9, 2'd3));
        fetch_one(line_pc(22'h000303, 6'd9, 2'd2));
        fetch_one(line_pc(22'h000101, 6'd9, 2'd1));
        fetch_one(line_pc(22'h000202, 6'd9, 2'd0));

        // Random fetches with stalls and the odd flush
        while (issued < random_reqs)
        begin
            @(posedge clk);
            taken = fetch_valid && fetch_ready && !stall;
            if (taken)
                issued++;
            rng = xorshift32(rng);
            stall <= rng[10:8] == 3'd0;
            flush <= rng[16:12] == 5'd0;
            if (taken || !fetch_valid)
            begin
                fetch_valid <= (rng[21:20] != 2'd0) && (issued < random_reqs);
                pc          <= pick_pc(rng);
            end
        end
        fetch_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;

        do
            @(negedge clk);
        while (!drained);
        repeat (2) @(negedge clk);

        $display("Requests %0d, checks %0d, errors %0d, assertion failures %0d",
                 requests, checks, errors, u_icache.u_props.fail_count);
        if (errors == 0 && u_icache.u_props.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb/icache_checker.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_checker
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`ICACHE_WORD_W-1:0] pc,
    input  logic                      fetch_valid,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      fetch_ready,
    input  logic [`ICACHE_WORD_W-1:0] inst,
    input  logic                      inst_valid,
    input  logic [`ICACHE_WORD_W-1:0] load_addr,
    input  logic                      mem_valid,
    input  logic                      mem_ready,
    output logic                      drained,
    output int unsigned               requests,
    output int unsigned               checks,
    output int unsigned               errors
);

    localparam int set_lo = `ICACHE_OFS_LOG;
    localparam int tag_lo = `ICACHE_OFS_LOG + `ICACHE_SET_LOG;

    // Reference model of tags, valid bits and MRU way per set
    logic [`ICACHE_TAG_W-1:0] tags [`ICACHE_SETS][`ICACHE_WAYS];
    logic [1:0]               line_valid [`ICACHE_SETS];
    logic                     mru [`ICACHE_SETS];

    // The one request in flight
    logic [`ICACHE_WORD_W-1:0] pend_pc;
    logic                      pend;
    logic                      pend_miss;
    logic                      pend_xfer;
    logic                      pend_filled;
    logic                      first_cmp;
    logic                      fill_next;

    assign drained = !pend;

    //////////////////////////////
    // Memory image and model lookups

    // Each word is a scramble of its own address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5ac3c3;
    endfunction

    function automatic logic [`ICACHE_LINE_W-1:0] line_image(input logic [31:0] addr);
        logic [`ICACHE_LINE_W-1:0] line;
        for (int w = 0; w < `ICACHE_LINE_W / `ICACHE_WORD_W; w++)
            line[w*32 +: 32] = mem_word({addr[31:4], 4'h0} + 32'(w * 4));
        return line;
    endfunction

    function automatic int set_of(input logic [31:0] addr);
        return int'(addr[tag_lo-1:set_lo]);
    endfunction

    // Way holding the line or -1 when it is absent
    function automatic int find_way(input logic [31:0] addr);
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
            if (line_valid[set_of(addr)][w] && tags[set_of(addr)][w] == addr[31:tag_lo])
                return w;
        end
        return -1;
    endfunction

    // Empty way first, else the way not used last
    task automatic install(input logic [31:0] addr);
        int s;
        int w;
        s = set_of(addr);
        if (!line_valid[s][0])
            w = 0;
        else if (!line_valid[s][1])
            w = 1;
        else
            w = mru[s] ? 0 : 1;
        tags[s][w]       = addr[31:tag_lo];
        line_valid[s][w] = 1'b1;
        mru[s]           = w[0];
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("error %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic fail_note(input string what);
        errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    //////////////////////////////
    // Cycle by cycle comparison

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            foreach (line_valid[s])
            begin
                line_valid[s] = '0;
                mru[s]        = 1'b0;
            end
            pend        = 1'b0;
            pend_filled = 1'b0;
            first_cmp   = 1'b0;
            fill_next   = 1'b0;
            requests    = 0;
            checks      = 0;
            errors      = 0;
        end
        else
        begin
            // Ready with no request open, on a hit and after the refill
            compare("fetch_ready", 32'(!pend || !pend_miss || pend_filled), 32'(fetch_ready));

            // Refill cycle writes the victim unless a flush cancels it
            if (fill_next && !flush)
            begin
                install(pend_pc);
                pend_filled = 1'b1;
            end
            fill_next = 1'b0;

            // Hit answers in the compare cycle and a miss stays quiet
            if (pend && first_cmp)
                compare("inst_valid", 32'(!pend_miss && !flush), 32'(inst_valid));
            first_cmp = 1'b0;

            if (mem_valid && !(pend && pend_miss))
                fail_note("Line request seen while no miss is outstanding");
            else if (mem_valid)
                compare("load_addr", {pend_pc[31:4], 4'h0}, load_addr);

            if (mem_valid && mem_ready)
            begin
                if (pend_xfer)
                    fail_note("Second line transfer for the same miss");
                pend_xfer = 1'b1;
                fill_next = 1'b1;
            end

            if (inst_valid && !stall)
            begin
                if (!pend)
                begin
                    fail_note("Instruction returned with no request outstanding");
                end
                else
                begin
                    if (pend_miss && !pend_xfer)
                        fail_note("Missed request returned before any line transfer");
                    compare("inst", mem_word(pend_pc), inst);
                    if (!pend_miss && find_way(pend_pc) >= 0)
                        mru[set_of(pend_pc)] = find_way(pend_pc) == 1;
                    pend = 1'b0;
                end
            end

            if (flush)
                pend = 1'b0;

            if (fetch_valid && fetch_ready && !stall)
            begin
                if (pend)
                    fail_note("New request taken while another is outstanding");
                pend        = 1'b1;
                pend_pc     = pc;
                pend_miss   = find_way(pc) < 0;
                pend_xfer   = 1'b0;
                pend_filled = 1'b0;
                first_cmp   = 1'b1;
                requests++;
            end
        end
    end

endmodule

//--- tb/icache_props.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_props
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      fetch_valid,
    input logic                      stall,
    input logic                      flush,
    input logic                      fetch_ready,
    input logic [`ICACHE_WORD_W-1:0] inst,
    input logic                      inst_valid,
    input logic [`ICACHE_WORD_W-1:0] load_addr,
    input logic                      mem_valid,
    input logic                      mem_ready
);

    int unsigned fail_count = 0;

    // Idle outputs in the cycle after a reset edge
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |=> !mem_valid && !inst_valid && fetch_ready)
    else
    begin
        $error("outputs not idle after reset");
        fail_count++;
    end

    // Line request held with a steady address until memory takes it
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> flush || (mem_valid && $stable(load_addr)))
    else
    begin
        $error("mem_valid or load_addr changed before mem_ready");
        fail_count++;
    end

    // Stalled instruction stays on the output
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall && inst_valid ##1 !flush |-> inst_valid && $stable(inst))
    else
    begin
        $error("inst or inst_valid changed during stall");
        fail_count++;
    end

    // Flushed request with no new one behind it is gone in the next cycle
    a_flush_cancel: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !(fetch_valid && fetch_ready && !stall) |=> !inst_valid && !mem_valid)
    else
    begin
        $error("instruction or line request survived a flush");
        fail_count++;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int period_ns = 8
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

//--- design/icache.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t pc,
    input  logic  fetch_valid,
    input  logic  stall,
    input  logic  flush,
    output logic  fetch_ready,
    output word_t inst,
    output logic  inst_valid,
    output word_t load_addr,
    output logic  mem_valid,
    input  logic  mem_ready,
    input  line_t mem_line
);

    word_t     req_addr;
    logic      req_valid;
    logic      accept;
    set_idx_t  req_set;
    set_idx_t  rd_set;
    tag_t      req_tag;
    word_sel_t word_sel;
    way_mask_t valid_q [`ICACHE_SETS];
    way_mask_t hit;
    way_mask_t victim;
    way_mask_t way_we;
    logic      lru_update;
    logic      from_refill;
    line_t     way_line [`ICACHE_WAYS];
    tag_t      way_tag [`ICACHE_WAYS];
    word_t     hit_word;

    icache_refill_if u_refill_if ();

    //////////////////////////////
    // Request register

    assign accept = fetch_valid && fetch_ready && !stall;

    always_ff @(posedge clk)
    begin
        if (accept)
            req_addr <= pc;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            req_valid <= 1'b0;
        else if (accept)
            req_valid <= 1'b1;
        else if (flush || (inst_valid && !stall))
            req_valid <= 1'b0;
    end

    assign req_set  = req_addr[`ICACHE_SET_LOG+`ICACHE_OFS_LOG-1:`ICACHE_OFS_LOG];
    assign req_tag  = req_addr[`ICACHE_WORD_W-1:`ICACHE_SET_LOG+`ICACHE_OFS_LOG];
    assign word_sel = req_addr[`ICACHE_OFS_LOG-1:2];

    // New set on accept, else reread the held one so a stall keeps the output
    assign rd_set = accept ? pc[`ICACHE_SET_LOG+`ICACHE_OFS_LOG-1:`ICACHE_OFS_LOG] : req_set;

    assign load_addr = {req_addr[`ICACHE_WORD_W-1:`ICACHE_OFS_LOG], {`ICACHE_OFS_LOG{1'b0}}};

    //////////////////////////////
    // Valid bits, set by a refill

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < `ICACHE_SETS; s++)
                valid_q[s] <= '0;
        end
        else if (|way_we)
        begin
            valid_q[req_set] <= valid_q[req_set] | way_we;
        end
    end

    //////////////////////////////
    // Ways

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        bram_sdp #(.width(`ICACHE_LINE_W), .depth(`ICACHE_SETS)) u_data (
            .clk    (clk),
            .addr_w (req_set),
            .addr_r (rd_set),
            .din_w  (u_refill_if.refill_line),
            .we_w   (way_we[w]),
            .dout_r (way_line[w])
        );

        bram_sdp #(.width(`ICACHE_TAG_W), .depth(`ICACHE_SETS)) u_tag (
            .clk    (clk),
            .addr_w (req_set),
            .addr_r (rd_set),
            .din_w  (req_tag),
            .we_w   (way_we[w]),
            .dout_r (way_tag[w])
        );

        assign hit[w] = valid_q[req_set][w] && (way_tag[w] == req_tag);
    end

    always_comb
    begin
        hit_word = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
            if (hit[w])
                hit_word = way_line[w][word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        end
    end

    // Refill word wins in the cycle after the array write
    assign inst       = from_refill ? u_refill_if.refill_word : hit_word;
    assign inst_valid = req_valid && !flush && (from_refill || (fetch_ready && |hit));

    assign u_refill_if.line     = mem_line;
    assign u_refill_if.word_sel = word_sel;

    lru_way_select u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (req_set),
        .hit        (hit),
        .update     (lru_update),
        .fill_way   (way_we),
        .fill       (|way_we),
        .valid_mask (valid_q[req_set]),
        .victim     (victim)
    );

    refill_buffer u_refill_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .refill (u_refill_if.buffer)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .stall       (stall),
        .req_pending (fetch_valid),
        .hit         (hit),
        .victim      (victim),
        .mem_ready   (mem_ready),
        .mem_valid   (mem_valid),
        .fetch_ready (fetch_ready),
        .way_we      (way_we),
        .lru_update  (lru_update),
        .from_refill (from_refill),
        .refill      (u_refill_if.ctrl)
    );

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          stall,
    input  logic          req_pending,
    input  way_mask_t     hit,
    input  way_mask_t     victim,
    input  logic          mem_ready,
    output logic          mem_valid,
    output logic          fetch_ready,
    output way_mask_t     way_we,
    output logic          lru_update,
    output logic          from_refill,
    icache_refill_if.ctrl refill
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        from_refill_q;
    logic        hit_any;
    logic        respond;
    logic        accept;

    //////////////////////////////
    // Handshake terms

    assign hit_any = |hit;

    // Compare cycle with an answer, either a hit or the refilled word
    assign respond = (state == st_lookup) && (from_refill_q || hit_any);

    // Low from the miss until the refilled word goes out
    assign fetch_ready = (state == st_idle) || respond;

    assign accept = req_pending && fetch_ready && !stall;

    //////////////////////////////
    // Next state

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (accept)
                    state_nxt = st_lookup;
            end
            st_lookup:
            begin
                if (!respond)
                    state_nxt = st_mem_req;
                else if (!stall)
                    state_nxt = accept ? st_lookup : st_idle;
            end
            st_mem_req:
            begin
                if (mem_ready)
                    state_nxt = st_refill;
            end
            st_refill:
            begin
                state_nxt = st_lookup;
            end
            default:
            begin
                state_nxt = st_idle;
            end
        endcase

        // Flush drops whatever was in flight; a new pc may still enter
        if (flush)
            state_nxt = accept ? st_lookup : st_idle;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state         <= st_idle;
            from_refill_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (flush)
                from_refill_q <= 1'b0;
            else if (state == st_refill)
                from_refill_q <= 1'b1;
            else if ((state == st_lookup) && !stall)
                from_refill_q <= 1'b0;
        end
    end

    //////////////////////////////
    // Outputs

    assign mem_valid      = (state == st_mem_req) && !flush;
    assign refill.capture = mem_valid && mem_ready;

    // One write cycle into the victim way
    assign way_we = ((state == st_refill) && !flush) ? victim : '0;

    // Only a hit that the fetch stage takes moves the LRU bit
    assign lru_update = respond && !from_refill_q && !stall && !flush;

    assign from_refill = from_refill_q;

endmodule

//--- design/refill_buffer.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module refill_buffer
    import icache_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    icache_refill_if.buffer refill
);

    line_t line_q;
    logic  line_held;
    word_t word_pick;

    // Line from memory, loaded on the completed transfer
    always_ff @(posedge clk)
    begin
        if (refill.capture)
        begin
            line_q <= refill.line;
        end
    end

    // Set once any line has arrived
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            line_held <= 1'b0;
        end
        else if (refill.capture)
        begin
            line_held <= 1'b1;
        end
    end

    assign word_pick = line_q[refill.word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

    // Nothing loaded yet, return zero
    assign refill.refill_word = line_held ? word_pick : '0;

    // Same line goes to the data array write port
    assign refill.refill_line = line_q;

endmodule

//--- design/lru_way_select.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module lru_way_select
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  set_idx_t  addr,
    input  way_mask_t hit,
    input  logic      update,
    input  way_mask_t fill_way,
    input  logic      fill,
    input  way_mask_t valid_mask,
    output way_mask_t victim
);

    // Most recently used way, one bit per set
    logic [`ICACHE_SETS-1:0] mru;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mru <= '0;
        end
        else if (fill)
        begin
            mru[addr] <= fill_way[1];
        end
        else if (update)
        begin
            mru[addr] <= hit[1];
        end
    end

    // Empty way first, then the one not used last
    always_comb
    begin
        if (!valid_mask[0])
            victim = way_mask_t'(2'b01);
        else if (!valid_mask[1])
            victim = way_mask_t'(2'b10);
        else if (mru[addr])
            victim = way_mask_t'(2'b01);
        else
            victim = way_mask_t'(2'b10);
    end

endmodule

//--- design/bram_sdp.sv
`timescale 1ns/1ns

module bram_sdp
    import icache_pkg::*;
#(
    parameter int width = 32,
    parameter int depth = 64
)
(
    input  logic             clk,
    input  set_idx_t         addr_w,
    input  set_idx_t         addr_r,
    input  logic [width-1:0] din_w,
    input  logic             we_w,
    output logic [width-1:0] dout_r
);

    logic [width-1:0] mem [depth];

    // Write port
    always_ff @(posedge clk)
    begin
        if (we_w)
        begin
            mem[addr_w] <= din_w;
        end
    end

    // Registered read, returns old data on a same-set write
    always_ff @(posedge clk)
    begin
        dout_r <= mem[addr_r];
    end

endmodule

//--- design/icache_refill_if.sv
`timescale 1ns/1ns

interface icache_refill_if
    import icache_pkg::*;
();
    // Line transfer done, load the buffer
    logic      capture;
    line_t     line;
    word_sel_t word_sel;

    // Buffer contents
    word_t     refill_word;
    line_t     refill_line;

    modport ctrl (output capture);

    modport buffer (input capture, input line, input word_sel,
                    output refill_word, output refill_line);

    modport datapath (output line, output word_sel,
                      input refill_word, input refill_line);
endinterface

//--- design/icache_pkg.sv
package icache_pkg;

`include "icache_consts.svh"

    // Instruction or byte address
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    // Address fields
    typedef logic [`ICACHE_SET_LOG-1:0] set_idx_t;
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // Word within a line, offset bits above the byte bits
    typedef logic [`ICACHE_OFS_LOG-3:0] word_sel_t;

    // One bit per way
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

    // Miss handling FSM
    typedef enum logic [1:0]
    {
        st_idle,
        st_lookup,
        st_mem_req,
        st_refill
    } ctrl_state_t;

endpackage

//--- include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Instruction and fetch address width
`define ICACHE_WORD_W 32

// One line is four instructions
`define ICACHE_LINE_W 128

// Geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 64
`define ICACHE_SET_LOG 6

// Byte offset within a line
`define ICACHE_OFS_LOG 4

// Whatever is left above index and offset
`define ICACHE_TAG_W 22

`endif
